//--- design/edram_config.svh
`ifndef EDRAM_CONFIG_SVH
`define EDRAM_CONFIG_SVH

// virtual bank count and the width of a bank index
`define EDRAM_NUMVBNK 4
`define EDRAM_BITVBNK 2

// rows per bank and the width of a row index
`define EDRAM_NUMSROW 16
`define EDRAM_BITSROW 4

// host address is the bank index on top of the row index
`define EDRAM_BITADDR 6

`define EDRAM_DATA_W  16

// cycles a bank holds its data with no refresh
`define EDRAM_RETAIN  48

`endif

//--- design/edram_pkg.sv
`include "edram_config.svh"

package edram_pkg;

  // one access on the shared bank port, at most one strobe set at a time
  typedef struct packed {
    logic                      read;
    logic                      write;
    logic [`EDRAM_BITVBNK-1:0] vbnk;
    logic [`EDRAM_BITSROW-1:0] srow;
    logic [`EDRAM_DATA_W-1:0]  wdata;
  } bank_acc_t;

  // a refresh aimed at one whole bank
  typedef struct packed {
    logic                      valid;
    logic [`EDRAM_BITVBNK-1:0] vbnk;
  } refr_req_t;

  // read result as seen by the host one cycle after the read strobe
  // rerr flags a row that was lost to decay or never written
  typedef struct packed {
    logic                     rvalid;
    logic                     rerr;
    logic [`EDRAM_DATA_W-1:0] rdata;
  } rd_resp_t;

endpackage

//--- design/edram_refresh_sched.sv
`timescale 1ns/1ps
`include "edram_config.svh"

module edram_refresh_sched (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 refr,
  input  logic                 refr_take,
  output edram_pkg::refr_req_t refr_pend
);

  // strobes beyond this many outstanding are dropped
  localparam int MAX_OUTST = 3;

  logic [1:0]                outst_cnt;
  logic [`EDRAM_BITVBNK-1:0] bank_ptr;
  logic                      take_ok;
  logic                      strobe_ok;

  // a take only counts while something is actually pending
  assign take_ok   = refr_take && (outst_cnt != 2'd0);
  assign strobe_ok = refr && ((outst_cnt != 2'(MAX_OUTST)) || take_ok);

  always_ff @(posedge clk) begin
    if (rst) begin
      outst_cnt <= 2'd0;
      bank_ptr  <= '0;
    end else begin
      if (strobe_ok && !take_ok) begin
        outst_cnt <= outst_cnt + 2'd1;
      end else if (take_ok && !strobe_ok) begin
        outst_cnt <= outst_cnt - 2'd1;
      end
      // next bank in round-robin order once the current one is served
      if (take_ok) begin
        if (bank_ptr == `EDRAM_BITVBNK'(`EDRAM_NUMVBNK - 1)) begin
          bank_ptr <= '0;
        end else begin
          bank_ptr <= bank_ptr + 1'b1;
        end
      end
    end
  end

  // the oldest outstanding request always targets the pointer bank
  always_comb begin
    refr_pend.valid = (outst_cnt != 2'd0);
    refr_pend.vbnk  = bank_ptr;
  end

endmodule

//--- design/edram_bank_arbiter.sv
`timescale 1ns/1ps

module edram_bank_arbiter (
  input  edram_pkg::bank_acc_t host_acc,
  input  edram_pkg::refr_req_t refr_pend,
  output edram_pkg::bank_acc_t acc,
  output edram_pkg::refr_req_t refr_go,
  output logic                 refr_take
);

  logic host_busy;
  logic bank_clash;

  // the host has no back-pressure, so its access always owns the array
  assign acc = host_acc;

  assign host_busy = host_acc.read || host_acc.write;

  // a refresh cannot share a bank with a live host access in the same cycle
  assign bank_clash = host_busy && (host_acc.vbnk == refr_pend.vbnk);

  // the pending refresh goes out now unless it collides, otherwise it
  // waits in the scheduler and is retried every following cycle
  assign refr_take = refr_pend.valid && !bank_clash;

  always_comb begin
    refr_go.valid = refr_take;
    refr_go.vbnk  = refr_pend.vbnk;
  end

endmodule

//--- design/edram_bank_array.sv
`timescale 1ns/1ps
`include "edram_config.svh"

module edram_bank_array (
  input  logic                 clk,
  input  logic                 rst,
  input  edram_pkg::bank_acc_t acc,
  input  edram_pkg::refr_req_t refr_go,
  output edram_pkg::rd_resp_t  resp
);

  localparam int RET_W = $clog2(`EDRAM_RETAIN + 1);

  logic [`EDRAM_DATA_W-1:0]  mem     [`EDRAM_NUMVBNK][`EDRAM_NUMSROW];
  logic [`EDRAM_NUMSROW-1:0] row_vld [`EDRAM_NUMVBNK];
  logic [RET_W-1:0]          ret_cnt [`EDRAM_NUMVBNK];
  logic [`EDRAM_NUMVBNK-1:0] refr_hit;
  logic [`EDRAM_NUMVBNK-1:0] expire;

  logic                      rvalid_q;
  logic                      rerr_q;
  logic [`EDRAM_DATA_W-1:0]  rdata_q;

  // one-hot view of which bank the refresh lands on this cycle
  // a bank decays on the edge where its counter steps from one to zero
  always_comb begin
    for (int b = 0; b < `EDRAM_NUMVBNK; b++) begin
      refr_hit[b] = refr_go.valid && (refr_go.vbnk == `EDRAM_BITVBNK'(b));
      expire[b]   = !refr_hit[b] && (ret_cnt[b] == RET_W'(1));
    end
  end

  // retention counters, reloaded by a refresh and otherwise running down
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int b = 0; b < `EDRAM_NUMVBNK; b++) begin
        ret_cnt[b] <= RET_W'(`EDRAM_RETAIN);
      end
    end else begin
      for (int b = 0; b < `EDRAM_NUMVBNK; b++) begin
        if (refr_hit[b]) begin
          ret_cnt[b] <= RET_W'(`EDRAM_RETAIN);
        end else if (ret_cnt[b] != '0) begin
          ret_cnt[b] <= ret_cnt[b] - 1'b1;
        end
      end
    end
  end

  // row valid bits, a write in the decay cycle still leaves its row valid
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int b = 0; b < `EDRAM_NUMVBNK; b++) begin
        row_vld[b] <= '0;
      end
    end else begin
      for (int b = 0; b < `EDRAM_NUMVBNK; b++) begin
        if (expire[b]) begin
          row_vld[b] <= '0;
        end
      end
      if (acc.write) begin
        row_vld[acc.vbnk][acc.srow] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (acc.write) begin
      mem[acc.vbnk][acc.srow] <= acc.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= acc.read;
    end
  end

  // rerr takes the valid bit as it stood before this edge's update
  always_ff @(posedge clk) begin
    if (acc.read) begin
      rdata_q <= mem[acc.vbnk][acc.srow];
      rerr_q  <= !row_vld[acc.vbnk][acc.srow];
    end
  end

  always_comb begin
    resp.rvalid = rvalid_q;
    resp.rerr   = rerr_q;
    resp.rdata  = rdata_q;
  end

endmodule

//--- design/edram_top.sv
`timescale 1ns/1ps
`include "edram_config.svh"

module edram_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      read,
  input  logic                      write,
  input  logic                      refr,
  input  logic [`EDRAM_BITADDR-1:0] addr,
  input  logic [`EDRAM_DATA_W-1:0]  wdata,
  output logic [`EDRAM_DATA_W-1:0]  rdata,
  output logic                      rvalid,
  output logic                      rerr
);

  import edram_pkg::*;

  bank_acc_t host_acc;
  bank_acc_t acc;
  refr_req_t refr_pend;
  refr_req_t refr_go;
  logic      refr_take;
  rd_resp_t  resp;

  // bank select sits in the upper address bits, row in the lower ones
  always_comb begin
    host_acc.read  = read;
    host_acc.write = write;
    host_acc.vbnk  = addr[`EDRAM_BITADDR-1 -: `EDRAM_BITVBNK];
    host_acc.srow  = addr[`EDRAM_BITSROW-1:0];
    host_acc.wdata = wdata;
  end

  edram_refresh_sched u_refresh_sched (
    .clk       (clk),
    .rst       (rst),
    .refr      (refr),
    .refr_take (refr_take),
    .refr_pend (refr_pend)
  );

  edram_bank_arbiter u_bank_arbiter (
    .host_acc  (host_acc),
    .refr_pend (refr_pend),
    .acc       (acc),
    .refr_go   (refr_go),
    .refr_take (refr_take)
  );

  edram_bank_array u_bank_array (
    .clk     (clk),
    .rst     (rst),
    .acc     (acc),
    .refr_go (refr_go),
    .resp    (resp)
  );

  assign rdata  = resp.rdata;
  assign rvalid = resp.rvalid;
  assign rerr   = resp.rerr;

endmodule

//--- test/edram_props.sv
`timescale 1ns/1ps

module edram_props (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 read,
  input  logic                 write,
  input  logic                 refr,
  input  edram_pkg::bank_acc_t acc,
  input  edram_pkg::refr_req_t refr_pend,
  input  edram_pkg::refr_req_t refr_go,
  input  logic                 rvalid
);

  int   fail_cnt = 0;
  logic host_busy;
  logic pend_blocked;

  assign host_busy    = acc.read || acc.write;
  assign pend_blocked = host_busy && (acc.vbnk == refr_pend.vbnk);

  host_strobe_mutex: assert property (@(posedge clk) disable iff (rst)
    $onehot0({read, write, refr}))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("read, write and refr asserted together");
    end

  refr_bank_free: assert property (@(posedge clk) disable iff (rst)
    refr_go.valid && host_busy |-> refr_go.vbnk != acc.vbnk)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("refresh issued to the bank the host is using");
    end

  // once the host is off the pending bank the request is served, so by the
  // next edge the scheduler has either emptied or moved to the next bank
  refr_not_stalled: assert property (@(posedge clk) disable iff (rst)
    refr_pend.valid && !pend_blocked |=>
      !refr_pend.valid || (refr_pend.vbnk != $past(refr_pend.vbnk)))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("pending refresh held back with its bank free");
    end

  read_gives_rvalid: assert property (@(posedge clk) disable iff (rst)
    read |=> rvalid)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("rvalid missing one cycle after a read");
    end

  no_stray_rvalid: assert property (@(posedge clk) disable iff (rst)
    !read |=> !rvalid)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("rvalid high without a read one cycle before");
    end

endmodule

//--- test/edram_checker.sv
`timescale 1ns/1ps
`include "edram_config.svh"

module edram_checker (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      read,
  input  logic                      write,
  input  logic                      refr,
  input  logic [`EDRAM_BITADDR-1:0] addr,
  input  logic [`EDRAM_DATA_W-1:0]  wdata,
  input  logic [`EDRAM_DATA_W-1:0]  rdata,
  input  logic                      rvalid,
  input  logic                      rerr,
  output int                        err_cnt
);

  localparam int NUM_ROWS = `EDRAM_NUMVBNK * `EDRAM_NUMSROW;

  // the flat model index is the host address itself, bank on top of row
  logic [`EDRAM_DATA_W-1:0] model_data [NUM_ROWS];
  logic                     model_vld  [NUM_ROWS];
  int                       last_refr  [`EDRAM_NUMVBNK];
  int                       cyc = 0;
  int                       ptr = 0;
  logic                     exp_rvalid = 1'b0;
  logic                     exp_rerr = 1'b0;
  logic [`EDRAM_DATA_W-1:0] exp_rdata = '0;

  initial err_cnt = 0;

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (rst) begin
      for (int b = 0; b < `EDRAM_NUMVBNK; b++) begin
        last_refr[b] = cyc;
      end
      for (int i = 0; i < NUM_ROWS; i++) begin
        model_vld[i] = 1'b0;
      end
      ptr = 0;
      exp_rvalid = 1'b0;
    end else begin
      // outputs seen here were registered at the previous edge
      if (rvalid !== exp_rvalid) begin
        err_cnt = err_cnt + 1;
        $display("** Error at %0t: rvalid expected %0b, got %0b", $time, exp_rvalid, rvalid);
      end else if (exp_rvalid && (rerr !== exp_rerr)) begin
        err_cnt = err_cnt + 1;
        $display("** Error at %0t: rerr expected %0b, got %0b", $time, exp_rerr, rerr);
      end else if (exp_rvalid && !exp_rerr && (rdata !== exp_rdata)) begin
        err_cnt = err_cnt + 1;
        $display("** Error at %0t: rdata expected %h, got %h", $time, exp_rdata, rdata);
      end
      exp_rvalid = read;
      if (read) begin
        exp_rerr  = !model_vld[addr];
        exp_rdata = model_data[addr];
      end
      // a bank left alone for the whole retention window forgets its rows
      for (int b = 0; b < `EDRAM_NUMVBNK; b++) begin
        if (cyc - last_refr[b] == `EDRAM_RETAIN) begin
          for (int r = 0; r < `EDRAM_NUMSROW; r++) begin
            model_vld[b * `EDRAM_NUMSROW + r] = 1'b0;
          end
        end
      end
      // the refresh reaches the bank one edge after its strobe
      if (refr) begin
        last_refr[ptr] = cyc + 1;
        ptr = (ptr + 1) % `EDRAM_NUMVBNK;
      end
      if (write) begin
        model_data[addr] = wdata;
        model_vld[addr]  = 1'b1;
      end
    end
  end

endmodule

//--- test/edram_tb.sv
`timescale 1ns/1ps
`include "edram_config.svh"

module edram_tb;

  localparam int REFR_EVERY = 8;
  localparam int GAP_LEN    = 100;
  localparam int MARGIN     = 200;

  typedef enum logic [1:0] {OP_IDLE, OP_READ, OP_WRITE, OP_REFR} op_e;

  typedef struct packed {
    op_e                       op;
    logic [`EDRAM_BITADDR-1:0] addr;
    logic [`EDRAM_DATA_W-1:0]  data;
  } stim_t;

  logic                      clk = 1'b0;
  logic                      rst;
  logic                      read;
  logic                      write;
  logic                      refr;
  logic [`EDRAM_BITADDR-1:0] addr;
  logic [`EDRAM_DATA_W-1:0]  wdata;
  logic [`EDRAM_DATA_W-1:0]  rdata;
  logic                      rvalid;
  logic                      rerr;
  int                        chk_errs;
  int                        total_errs;
  stim_t                     stim_q[$];
  logic [31:0]               lcg_state;
  logic                      refr_on;
  logic                      table_ready = 1'b0;

  always #10 clk = ~clk;

  edram_top u_edram_top (
    .clk    (clk),
    .rst    (rst),
    .read   (read),
    .write  (write),
    .refr   (refr),
    .addr   (addr),
    .wdata  (wdata),
    .rdata  (rdata),
    .rvalid (rvalid),
    .rerr   (rerr)
  );

  edram_checker u_edram_checker (
    .clk     (clk),
    .rst     (rst),
    .read    (read),
    .write   (write),
    .refr    (refr),
    .addr    (addr),
    .wdata   (wdata),
    .rdata   (rdata),
    .rvalid  (rvalid),
    .rerr    (rerr),
    .err_cnt (chk_errs)
  );

  bind edram_top edram_props u_edram_props (
    .clk       (clk),
    .rst       (rst),
    .read      (read),
    .write     (write),
    .refr      (refr),
    .acc       (acc),
    .refr_pend (refr_pend),
    .refr_go   (refr_go),
    .rvalid    (rvalid)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [`EDRAM_DATA_W-1:0] rand_word();
    lcg_state = lcg_next(lcg_state);
    return lcg_state[31:16];
  endfunction

  // a refresh slot is slipped in ahead of every eighth entry
  task automatic add_entry(input op_e op, input logic [`EDRAM_BITADDR-1:0] a,
                           input logic [`EDRAM_DATA_W-1:0] d);
    stim_t e;
    if (refr_on && (stim_q.size() % REFR_EVERY == 0)) begin
      e.op   = OP_REFR;
      e.addr = '0;
      e.data = '0;
      stim_q.push_back(e);
    end
    e.op   = op;
    e.addr = a;
    e.data = d;
    stim_q.push_back(e);
  endtask

  task automatic fill_table();
    logic [`EDRAM_BITADDR-1:0] a;
    // nothing written yet, so every read flags rerr
    for (int i = 0; i < 16; i++) begin
      add_entry(OP_READ, `EDRAM_BITADDR'(i * 5), '0);
    end
    for (int i = 0; i < 16; i++) begin
      a = `EDRAM_BITADDR'(i * 7 + 3);
      add_entry(OP_WRITE, a, rand_word());
      add_entry(OP_READ, a, '0);
    end
    // every row, with the bank changing on each access
    for (int i = 0; i < 64; i++) begin
      add_entry(OP_WRITE, `EDRAM_BITADDR'(((i % 4) << 4) | (i / 4)), rand_word());
    end
    for (int i = 0; i < 64; i++) begin
      add_entry(OP_READ, `EDRAM_BITADDR'(((i % 4) << 4) | (i / 4)), '0);
    end
    refr_on = 1'b0;
    for (int i = 0; i < GAP_LEN; i++) begin
      add_entry(OP_IDLE, '0, '0);
    end
    refr_on = 1'b1;
    for (int i = 0; i < 16; i++) begin
      add_entry(OP_READ, `EDRAM_BITADDR'(i * 4 + 1), '0);
    end
    for (int i = 0; i < 8; i++) begin
      a = `EDRAM_BITADDR'(i * 9);
      add_entry(OP_WRITE, a, rand_word());
      add_entry(OP_READ, a, '0);
    end
  endtask

  task automatic apply_entry(input stim_t s);
    read  = (s.op == OP_READ);
    write = (s.op == OP_WRITE);
    refr  = (s.op == OP_REFR);
    addr  = s.addr;
    wdata = s.data;
  endtask

  initial begin
    rst       = 1'b1;
    read      = 1'b0;
    write     = 1'b0;
    refr      = 1'b0;
    addr      = '0;
    wdata     = '0;
    lcg_state = 32'd38;
    refr_on   = 1'b1;
    fill_table();
    table_ready = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    foreach (stim_q[i]) begin
      apply_entry(stim_q[i]);
      @(negedge clk);
    end
    apply_entry('0);
    repeat (4) @(negedge clk);
    total_errs = chk_errs + u_edram_top.u_edram_props.fail_cnt;
    $display("errors: %0d (%0d compare, %0d assertion)", total_errs, chk_errs,
             u_edram_top.u_edram_props.fail_cnt);
    if (total_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    wait (table_ready);
    #((stim_q.size() + MARGIN) * 20);
    $display("timeout: the stimulus table did not finish in time");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- all.f
+incdir+design
design/edram_pkg.sv
design/edram_refresh_sched.sv
design/edram_bank_arbiter.sv
design/edram_bank_array.sv
design/edram_top.sv
test/edram_props.sv
test/edram_checker.sv
test/edram_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module edram_tb -f all.f -o edram_sim
./obj_dir/edram_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
